// ==== hdl/core_pkg.sv ====
// RV32I subset only: no CSRs, no M extension, word-sized memory access; XLEN must stay 32.
package core_pkg;

	localparam int XLEN = 32; // Data and address width of the core.

	// Major opcodes that the decoder recognizes.
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B // Operand B straight through, used by LUI.
	} alu_op_e;

	typedef enum logic [1:0] {
		RD_SRC_ALU,
		RD_SRC_MEM,
		RD_SRC_LINK // Return address pc+4.
	} rd_src_e;

	typedef enum logic [1:0] {
		SRC_A_RS1,
		SRC_A_PC,
		SRC_A_ZERO
	} src_a_e;

	typedef struct packed {
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		logic [XLEN-1:0] imm;       // Sign-extended immediate.
		alu_op_e         alu_op;
		src_a_e          src_a;
		logic            src_b_imm; // Operand B is imm instead of rs2.
		rd_src_e         rd_src;
		logic            rd_we;
		logic            mem_re;
		logic            mem_we;
		logic            is_branch;
		logic            is_jal;
		logic            is_jalr;
		logic [2:0]      funct3;    // Branch condition.
	} decode_t;

	typedef struct packed {
		logic            valid;
		logic [4:0]      rd;
		logic [XLEN-1:0] data;
	} commit_t;

	typedef struct packed {
		logic            we;
		logic [XLEN-1:0] addr; // Word index, not byte address.
		logic [31:0]     data;
	} prog_t;

endpackage

// ==== hdl/pcu.sv ====
// Single-cycle pc update; no traps or interrupts, so dnpc comes only from jumps and branches.
module pcu import core_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            take_branch,
	input  decode_t         dec,
	input  logic [XLEN-1:0] alu_result,
	output logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] dnpc
);

	logic [XLEN-1:0] pc_seq;
	logic [XLEN-1:0] pc_tgt;

	assign pc_seq = pc + XLEN'(4);  // Fall-through address.
	assign pc_tgt = pc + dec.imm;   // Branch and JAL target.

	always_comb begin
		if (dec.is_jalr) begin
			dnpc = {alu_result[XLEN-1:1], 1'b0}; // JALR clears bit 0 of rs1+imm.
		end else if (take_branch) begin
			dnpc = pc_tgt;
		end else begin
			dnpc = pc_seq;
		end
	end

	// The pc register, one cycle from dnpc.
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else begin
			pc <= dnpc;
		end
	end

endmodule

// ==== hdl/ifu.sv ====
// IMEM_WORDS must be a power of two of at least 2; load and fetch addresses wrap silently.
module ifu import core_pkg::*; #(
	parameter int unsigned IMEM_WORDS = 256
) (
	input  logic            clk,
	input  prog_t           prog,
	input  logic [XLEN-1:0] pc,
	output logic [31:0]     inst
);

	localparam int AW = $clog2(IMEM_WORDS);

	logic [31:0]   mem [IMEM_WORDS]; // Instruction words.
	logic [AW-1:0] rd_idx;
	logic [AW-1:0] wr_idx;

	assign rd_idx = pc[AW+1:2];       // Byte pc to word index.
	assign wr_idx = prog.addr[AW-1:0]; // Load port is already a word index.

	// Program loading is independent of reset.
	always_ff @(posedge clk) begin
		if (prog.we) begin
			mem[wr_idx] <= prog.data;
		end
	end

	assign inst = mem[rd_idx]; // Asynchronous fetch.

endmodule

// ==== hdl/idu.sv ====
// Decodes the RV32I subset only; any other opcode becomes a no-op with every enable cleared.
module idu import core_pkg::*; (
	input  logic [31:0] inst,
	output decode_t     dec
);

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic            alt;    // inst[30] selects sub or sra where it applies.
	alu_op_e         alu_fn;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];

	// Immediate formats of the base ISA.
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// There is no subi, so OP-IMM only honors inst[30] on right shifts.
	assign alt = inst[30] && (opcode == OPC_OP || funct3 == 3'b101);

	always_comb begin
		case (funct3)
			3'b000:  alu_fn = alt ? ALU_SUB : ALU_ADD;
			3'b001:  alu_fn = ALU_SLL;
			3'b010:  alu_fn = ALU_SLT;
			3'b011:  alu_fn = ALU_SLTU;
			3'b100:  alu_fn = ALU_XOR;
			3'b101:  alu_fn = alt ? ALU_SRA : ALU_SRL;
			3'b110:  alu_fn = ALU_OR;
			default: alu_fn = ALU_AND;
		endcase
	end

	always_comb begin
		dec        = '0;
		dec.rs1    = inst[19:15];
		dec.rs2    = inst[24:20];
		dec.rd     = inst[11:7];
		dec.funct3 = funct3;
		dec.alu_op = ALU_ADD;
		dec.src_a  = SRC_A_RS1;
		dec.rd_src = RD_SRC_ALU;
		case (opcode)
			OPC_OP: begin
				dec.alu_op = alu_fn;
				dec.rd_we  = 1'b1;
			end
			OPC_OP_IMM: begin
				dec.alu_op    = alu_fn;
				dec.imm       = imm_i;
				dec.src_b_imm = 1'b1;
				dec.rd_we     = 1'b1;
			end
			OPC_LUI: begin
				dec.alu_op    = ALU_PASS_B;
				dec.src_a     = SRC_A_ZERO;
				dec.imm       = imm_u;
				dec.src_b_imm = 1'b1;
				dec.rd_we     = 1'b1;
			end
			OPC_AUIPC: begin
				dec.src_a     = SRC_A_PC; // pc plus the upper immediate.
				dec.imm       = imm_u;
				dec.src_b_imm = 1'b1;
				dec.rd_we     = 1'b1;
			end
			OPC_JAL: begin
				dec.src_a     = SRC_A_PC;
				dec.imm       = imm_j;
				dec.src_b_imm = 1'b1;
				dec.rd_src    = RD_SRC_LINK;
				dec.rd_we     = 1'b1;
				dec.is_jal    = 1'b1;
			end
			OPC_JALR: begin
				dec.imm       = imm_i; // Target is rs1+imm from the ALU.
				dec.src_b_imm = 1'b1;
				dec.rd_src    = RD_SRC_LINK;
				dec.rd_we     = 1'b1;
				dec.is_jalr   = 1'b1;
			end
			OPC_BRANCH: begin
				dec.src_a     = SRC_A_PC;
				dec.imm       = imm_b;
				dec.src_b_imm = 1'b1;
				dec.is_branch = 1'b1;
			end
			OPC_LOAD: begin
				dec.imm       = imm_i;
				dec.src_b_imm = 1'b1;
				dec.rd_src    = RD_SRC_MEM;
				dec.rd_we     = 1'b1;
				dec.mem_re    = 1'b1;
			end
			OPC_STORE: begin
				dec.imm       = imm_s;
				dec.src_b_imm = 1'b1;
				dec.mem_we    = 1'b1;
			end
			default: ; // Unknown opcode, nothing is written.
		endcase
	end

endmodule

// ==== hdl/gpr.sv ====
// Registers have no reset value, so software must write a register before reading it.
module gpr import core_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	input  logic [4:0]      rd,
	input  logic            rd_we,
	input  logic [XLEN-1:0] x_rd,
	output logic [XLEN-1:0] x_rs1,
	output logic [XLEN-1:0] x_rs2
);

	logic [XLEN-1:0] regs [1:31]; // x0 has no storage.
	logic            wr_en;

	assign wr_en = rd_we && !rst && (rd != 5'd0);

	always_ff @(posedge clk) begin
		if (wr_en) begin
			regs[rd] <= x_rd;
		end
	end

	// Reads are combinational and see the value written at the last edge.
	assign x_rs1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign x_rs2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== hdl/exu.sv ====
// Purely combinational; shifts use the low five bits of operand B as RV32 requires.
module exu import core_pkg::*; (
	input  decode_t         dec,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] x_rs1,
	input  logic [XLEN-1:0] x_rs2,
	output logic [XLEN-1:0] alu_result,
	output logic            take_branch
);

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [4:0]      shamt;
	logic            eq;
	logic            lt;
	logic            ltu;
	logic            cond;

	always_comb begin
		case (dec.src_a)
			SRC_A_RS1: op_a = x_rs1;
			SRC_A_PC:  op_a = pc;
			default:   op_a = '0;
		endcase
	end

	assign op_b  = dec.src_b_imm ? dec.imm : x_rs2;
	assign shamt = op_b[4:0];

	always_comb begin
		case (dec.alu_op)
			ALU_ADD:  alu_result = op_a + op_b;
			ALU_SUB:  alu_result = op_a - op_b;
			ALU_SLL:  alu_result = op_a << shamt;
			ALU_SLT:  alu_result = XLEN'($signed(op_a) < $signed(op_b));
			ALU_SLTU: alu_result = XLEN'(op_a < op_b);
			ALU_XOR:  alu_result = op_a ^ op_b;
			ALU_SRL:  alu_result = op_a >> shamt;
			ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
			ALU_OR:   alu_result = op_a | op_b;
			ALU_AND:  alu_result = op_a & op_b;
			default:  alu_result = op_b; // Pass-through for LUI.
		endcase
	end

	// The ALU is busy with the target, so branches compare the registers here.
	assign eq  = (x_rs1 == x_rs2);
	assign lt  = ($signed(x_rs1) < $signed(x_rs2));
	assign ltu = (x_rs1 < x_rs2);

	always_comb begin
		case (dec.funct3)
			3'b000:  cond = eq;
			3'b001:  cond = !eq;
			3'b100:  cond = lt;
			3'b101:  cond = !lt;
			3'b110:  cond = ltu;
			3'b111:  cond = !ltu;
			default: cond = 1'b0; // Reserved encodings never branch.
		endcase
	end

	assign take_branch = (dec.is_branch && cond) || dec.is_jal || dec.is_jalr;

endmodule

// ==== hdl/mau.sv ====
// Word access only: addr[1:0] is ignored and addresses beyond DMEM_WORDS wrap.
module mau import core_pkg::*; #(
	parameter int unsigned DMEM_WORDS = 256
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            mem_we,
	input  logic [XLEN-1:0] addr,
	input  logic [XLEN-1:0] w_data,
	output logic [XLEN-1:0] r_data
);

	localparam int AW = $clog2(DMEM_WORDS);

	logic [XLEN-1:0] mem [DMEM_WORDS];
	logic [AW-1:0]   idx;

	assign idx = addr[AW+1:2]; // Byte address to word index.

	// Data memory starts out all zero.
	initial begin
		for (int i = 0; i < DMEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_we && !rst) begin
			mem[idx] <= w_data;
		end
	end

	assign r_data = mem[idx]; // Load data is ready in the same cycle.

endmodule

// ==== hdl/top.sv ====
// One instruction retires per clock with no stalls; load the program only while rst is high.
module top import core_pkg::*; #(
	parameter int unsigned     IMEM_WORDS = 256,
	parameter int unsigned     DMEM_WORDS = 256,
	parameter logic [XLEN-1:0] RESET_PC   = '0
) (
	input  logic            clk,
	input  logic            rst,
	input  prog_t           prog,
	output logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] dnpc,
	output logic [31:0]     inst,
	output commit_t         commit
);

	decode_t         dec;
	logic [XLEN-1:0] x_rs1;
	logic [XLEN-1:0] x_rs2;
	logic [XLEN-1:0] x_rd;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] mem_r_data;
	logic [XLEN-1:0] load_data;
	logic            take_branch;

	pcu #(.RESET_PC(RESET_PC)) u_pcu (
		.clk(clk),
		.rst(rst),
		.take_branch(take_branch),
		.dec(dec),
		.alu_result(alu_result),
		.pc(pc),
		.dnpc(dnpc)
	);

	ifu #(.IMEM_WORDS(IMEM_WORDS)) u_ifu (
		.clk(clk),
		.prog(prog),
		.pc(pc),
		.inst(inst)
	);

	idu u_idu (
		.inst(inst),
		.dec(dec)
	);

	gpr u_gpr (
		.clk(clk),
		.rst(rst),
		.rs1(dec.rs1),
		.rs2(dec.rs2),
		.rd(dec.rd),
		.rd_we(dec.rd_we),
		.x_rd(x_rd),
		.x_rs1(x_rs1),
		.x_rs2(x_rs2)
	);

	exu u_exu (
		.dec(dec),
		.pc(pc),
		.x_rs1(x_rs1),
		.x_rs2(x_rs2),
		.alu_result(alu_result),
		.take_branch(take_branch)
	);

	mau #(.DMEM_WORDS(DMEM_WORDS)) u_mau (
		.clk(clk),
		.rst(rst),
		.mem_we(dec.mem_we),
		.addr(alu_result),
		.w_data(x_rs2),
		.r_data(mem_r_data)
	);

	assign load_data = dec.mem_re ? mem_r_data : '0; // Only loads see memory data.

	// Write-back select.
	always_comb begin
		case (dec.rd_src)
			RD_SRC_MEM:  x_rd = load_data;
			RD_SRC_LINK: x_rd = pc + XLEN'(4);
			default:     x_rd = alu_result;
		endcase
	end

	// The commit trace mirrors the register file write.
	assign commit.valid = dec.rd_we && (dec.rd != 5'd0) && !rst;
	assign commit.rd    = dec.rd;
	assign commit.data  = x_rd;

endmodule

// ==== dv/core_assertions.sv ====
// Assumes a synchronous active-high rst and a word-aligned RESET_PC; failures show only as $error.
module core_assert import core_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input logic            clk,
	input logic            rst,
	input logic [XLEN-1:0] pc,
	input commit_t         commit
);

	timeunit 1ns;
	timeprecision 1ps;

	// A reset edge puts the pc at the reset address.
	a_reset_pc: assert property (@(posedge clk) rst |=> pc == RESET_PC)
		else $error("pc differs from RESET_PC after a reset cycle");

	a_no_commit_in_reset: assert property (@(posedge clk) rst |-> !commit.valid)
		else $error("commit.valid is high during reset");

	a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("pc is not word aligned");

	a_no_x0_commit: assert property (@(posedge clk) commit.valid |-> commit.rd != 5'd0)
		else $error("commit is valid with rd zero");

endmodule

// ==== dv/tb_top.sv ====
// Run from the project root so the stimulus file is found; rst stays high during program load.
module tb_top import core_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int    RESET_CYCLES = 4;
	localparam string STIM_FILE    = "dv/core_stimulus.txt";

	logic            clk;
	logic            rst;
	prog_t           prog;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] dnpc;
	logic [31:0]     inst;
	commit_t         commit;

	logic [31:0] load_addr [$]; // Word index of each program word.
	logic [31:0] load_word [$];
	logic [31:0] exp_pc [$];    // One entry per retired instruction.
	logic [31:0] exp_rd [$];
	logic [31:0] exp_data [$];
	bit          loaded;
	int          cycles;
	int          cycle_limit;

	top #(
		.IMEM_WORDS(64),
		.DMEM_WORDS(64),
		.RESET_PC(32'h0000_0000)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.prog(prog),
		.pc(pc),
		.dnpc(dnpc),
		.inst(inst),
		.commit(commit)
	);

	bind top core_assert #(.RESET_PC(RESET_PC)) u_core_assert (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.commit(commit)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Looks up the program word loaded at the word index of a byte address.
	function automatic logic [31:0] program_word(input logic [31:0] byte_addr);
		logic [31:0] word;
		word = 'x;
		foreach (load_addr[k]) begin
			if (load_addr[k] == (byte_addr >> 2)) begin
				word = load_word[k];
			end
		end
		return word;
	endfunction

	// Only lines that start with P or E carry data.
	task automatic read_stimulus();
		int          fd;
		int          n;
		string       line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file %s", STIM_FILE);
			abort_run();
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line.getc(0) == "P") begin
					n = $sscanf(line, "P %h %h", a, b);
					if (n != 2) begin
						$display("Malformed program line in the stimulus file: %s", line);
						abort_run();
					end
					load_addr.push_back(a);
					load_word.push_back(b);
				end else if (line.len() > 0 && line.getc(0) == "E") begin
					n = $sscanf(line, "E %h %d %h", a, b, c);
					if (n != 3) begin
						$display("Malformed expect line in the stimulus file: %s", line);
						abort_run();
					end
					exp_pc.push_back(a);
					exp_rd.push_back(b);
					exp_data.push_back(c);
				end
			end
			$fclose(fd);
		end
	endtask

	// The run may not last longer than loading plus checking plus some slack.
	initial begin
		cycles = 0;
		wait (loaded);
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > cycle_limit) begin
				$display("Timeout: the commit trace did not finish within %0d cycles", cycle_limit);
				abort_run();
			end
		end
	end

	initial begin
		rst  = 1'b1;
		prog = '0;
		read_stimulus();
		if (exp_pc.size() == 0) begin
			$display("The stimulus file holds no expected commits");
			abort_run();
		end
		cycle_limit = load_addr.size() + exp_pc.size() + 20;
		loaded      = 1'b1;
		foreach (load_addr[i]) begin
			@(negedge clk);
			prog.we   = 1'b1;
			prog.addr = load_addr[i];
			prog.data = load_word[i];
		end
		@(negedge clk);
		prog = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		// Outputs describe the retiring instruction until the edge that retires it.
		foreach (exp_pc[i]) begin
			@(posedge clk);
			check_value("pc", pc, exp_pc[i]);
			check_value("inst", inst, program_word(exp_pc[i]));
			if (i + 1 < exp_pc.size()) begin
				check_value("dnpc", dnpc, exp_pc[i+1]);
			end
			check_value("commit.valid", 32'(commit.valid), 32'(exp_rd[i] != 0));
			if (exp_rd[i] != 0) begin
				check_value("commit.rd", 32'(commit.rd), exp_rd[i]);
				check_value("commit.data", commit.data, exp_data[i]);
			end
		end
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== dv/core_stimulus.txt ====
# P <word index, hex> <instruction, hex>
# E <pc, hex> <rd, decimal, 0 means no valid commit> <data, hex>
P 00 ffb00093
P 01 00300113
P 02 401101b3
P 03 0020a233
P 04 0020b2b3
P 05 4020d333
P 06 0020d3b3
P 07 fff0c793
P 08 00411813
P 09 12345437
P 0a 00001497
P 0b 00102823
P 0c 01002503
P 0d 00700013
P 0e 002005b3
P 0f 00258463
P 10 00100613
P 11 00259463
P 12 00c006ef
P 13 00200613
P 14 0000006f
P 15 00468767
# addi, sub, slt/sltu and sra/srl on a negative operand
E 00000000 1 fffffffb
E 00000004 2 00000003
E 00000008 3 00000008
E 0000000c 4 00000001
E 00000010 5 00000000
E 00000014 6 ffffffff
E 00000018 7 1fffffff
E 0000001c 15 00000004
E 00000020 16 00000030
# lui, auipc, then sw and lw at byte address 16
E 00000024 8 12345000
E 00000028 9 00001028
E 0000002c 0 00000000
E 00000030 10 fffffffb
# write to x0, read of x0, taken beq, not-taken bne, jal, jalr, self-jump
E 00000034 0 00000000
E 00000038 11 00000003
E 0000003c 0 00000000
E 00000044 0 00000000
E 00000048 13 0000004c
E 00000054 14 00000058
E 00000050 0 00000000
E 00000050 0 00000000

// ==== src.f ====
hdl/core_pkg.sv
hdl/pcu.sv
hdl/ifu.sv
hdl/idu.sv
hdl/gpr.sv
hdl/exu.sv
hdl/mau.sv
hdl/top.sv
dv/core_assertions.sv
dv/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

if ! verilator --binary --assert -j 0 --top-module tb_top -f src.f; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_top 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
	exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
